// File: include/daq_tx_config.svh
`ifndef DAQ_TX_CONFIG_SVH
`define DAQ_TX_CONFIG_SVH

////////////////////////////////////////
// Word geometry
////////////////////////////////////////

`define DAQ_WORD_W 16 // Serializer word, two octets
`define DAQ_K_W 2     // One K flag per octet, bit 0 goes out first

////////////////////////////////////////
// 8b/10b octets
////////////////////////////////////////

`define K28_5 8'hBC    // Comma
`define D16_2 8'h50    // Second half of /I2/
`define K27_7 8'hFB    // /S/ start of packet
`define K29_7 8'hFD    // /T/ end of packet
`define K23_7 8'hF7    // /R/ carrier extend
`define PRMBL 8'h55    // Preamble octet
`define SOF_BYTE 8'hD5 // Start of frame delimiter

////////////////////////////////////////
// Ordered-set words, high octet on the left
////////////////////////////////////////

`define IDLE2_W {`D16_2, `K28_5}
`define SOP_PRE_W {`PRMBL, `K27_7}
`define PREAMBLE_W {`PRMBL, `PRMBL}
`define SOF_PRE_W {`SOF_BYTE, `PRMBL}
`define EOP_W {`K23_7, `K29_7}
`define CEXT_W {`K23_7, `K23_7}

// Ethernet CRC-32, reflected, seeded with all ones and inverted at the end
`define CRC_POLY 32'hEDB88320

// Plain preamble words between the SOP word and the SOF word
`define PREAMBLE_WORDS 3

`endif

// File: rtl/daq_tx_pkg.sv
package daq_tx_pkg;

	////////////////////////////////////////
	// Ordered-set codes, ROM address
	////////////////////////////////////////

	typedef enum logic [2:0]
	{
		OS_IDLE = 3'd0, // /I2/ between packets
		OS_SOP  = 3'd1, // /S/ with first preamble octet
		OS_PRE  = 3'd2, // Plain preamble
		OS_SOF  = 3'd3, // Last preamble octet and SFD
		OS_DATA = 3'd4, // Payload or CRC slot, word comes from elsewhere
		OS_EOP  = 3'd5, // /T/ /R/
		OS_CEXT = 3'd6  // /R/ /R/
	} os_code_t;

	////////////////////////////////////////
	// Frame sequencer states
	////////////////////////////////////////

	typedef enum logic [2:0]
	{
		ST_IDLE     = 3'd0,
		ST_PREAMBLE = 3'd1, // SOP, preamble and SOF words
		ST_DATA     = 3'd2, // Acknowledge high
		ST_CRC_HI   = 3'd3,
		ST_CRC_LO   = 3'd4,
		ST_EOP      = 3'd5,
		ST_CEXT     = 3'd6
	} frm_state_t;

endpackage

// File: rtl/frame_ctrl_if.sv
`timescale 1ns/1ps

`include "daq_tx_config.svh"

// Per-cycle frame controls, sequencer to CRC and output mux
interface frame_ctrl_if;

	logic clr_crc;                    // Seed pulse, last preamble cycle
	logic crc_calc;                   // Payload word taken this cycle
	logic crc_vld;                    // CRC word slot this cycle
	logic [`DAQ_WORD_W-1:0] rom_word; // Registered ordered-set word
	logic [`DAQ_K_W-1:0] rom_k;       // Its K flags

	modport seq
	(
		output clr_crc, crc_calc, crc_vld, rom_word, rom_k
	);

	modport crc
	(
		input clr_crc, crc_calc, crc_vld
	);

	modport mux
	(
		input crc_calc, crc_vld, rom_word, rom_k
	);

endinterface

// File: rtl/frame_sequencer.sv
`timescale 1ns/1ps

`include "daq_tx_config.svh"

module frame_sequencer
(
	input logic usr_clk_wordwise,
	input logic arst,
	input logic txd_vld_i,
	output logic tx_ack_o,
	frame_ctrl_if.seq ctrl
);

	localparam logic [2:0] PRE_LAST = 3'(`PREAMBLE_WORDS + 1); // SOF slot

	daq_tx_pkg::frm_state_t state;
	daq_tx_pkg::frm_state_t state_nxt;
	daq_tx_pkg::os_code_t os_code;
	logic [2:0] pre_cnt; // Word index inside the preamble
	logic crc_first;     // Drain cycle after the last payload word

	////////////////////////////////////////
	// State machine
	////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			daq_tx_pkg::ST_IDLE:
				if (txd_vld_i)
					state_nxt = daq_tx_pkg::ST_PREAMBLE; // Request sampled
			daq_tx_pkg::ST_PREAMBLE:
				if (pre_cnt == PRE_LAST)
					state_nxt = daq_tx_pkg::ST_DATA;
			daq_tx_pkg::ST_DATA:
				if (!txd_vld_i)
					state_nxt = daq_tx_pkg::ST_CRC_HI; // User ended the payload
			daq_tx_pkg::ST_CRC_HI: state_nxt = daq_tx_pkg::ST_CRC_LO;
			daq_tx_pkg::ST_CRC_LO: state_nxt = daq_tx_pkg::ST_EOP;
			daq_tx_pkg::ST_EOP: state_nxt = daq_tx_pkg::ST_CEXT;
			default: state_nxt = daq_tx_pkg::ST_IDLE; // CEXT slot issues the idle gap
		endcase
	end

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			state <= daq_tx_pkg::ST_IDLE;
			pre_cnt <= 3'd0;
		end
		else
		begin
			state <= state_nxt;
			if (state == daq_tx_pkg::ST_PREAMBLE)
				pre_cnt <= pre_cnt + 3'd1;
			else
				pre_cnt <= 3'd0;
		end
	end

	////////////////////////////////////////
	// Controls
	////////////////////////////////////////

	// Codes lead the state names by one slot: the cycle where the user drops
	// the request already carries the CRC high word
	assign crc_first = (state == daq_tx_pkg::ST_DATA) && !txd_vld_i;

	assign tx_ack_o = (state == daq_tx_pkg::ST_DATA);
	assign ctrl.crc_calc = tx_ack_o && txd_vld_i;                   // One word taken
	assign ctrl.crc_vld = crc_first || (state == daq_tx_pkg::ST_CRC_HI); // Both CRC words
	assign ctrl.clr_crc = (state == daq_tx_pkg::ST_PREAMBLE) && (pre_cnt == PRE_LAST);

	// State to ordered-set code
	always_comb
	begin
		case (state)
			daq_tx_pkg::ST_PREAMBLE:
				if (pre_cnt == 3'd0)
					os_code = daq_tx_pkg::OS_SOP;
				else if (pre_cnt == PRE_LAST)
					os_code = daq_tx_pkg::OS_SOF;
				else
					os_code = daq_tx_pkg::OS_PRE;
			daq_tx_pkg::ST_DATA: os_code = daq_tx_pkg::OS_DATA;
			daq_tx_pkg::ST_CRC_HI: os_code = daq_tx_pkg::OS_DATA; // CRC low slot
			daq_tx_pkg::ST_CRC_LO: os_code = daq_tx_pkg::OS_EOP;
			daq_tx_pkg::ST_EOP: os_code = daq_tx_pkg::OS_CEXT;
			default: os_code = daq_tx_pkg::OS_IDLE;
		endcase
	end

	////////////////////////////////////////
	// Ordered-set ROM, word and K flag
	////////////////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			ctrl.rom_word <= `IDLE2_W;
			ctrl.rom_k <= 2'b01;
		end
		else
		begin
			case (os_code)
				daq_tx_pkg::OS_SOP:
				begin
					ctrl.rom_word <= `SOP_PRE_W;
					ctrl.rom_k <= 2'b01; // K27.7 in the low octet
				end
				daq_tx_pkg::OS_PRE:
				begin
					ctrl.rom_word <= `PREAMBLE_W;
					ctrl.rom_k <= 2'b00;
				end
				daq_tx_pkg::OS_SOF:
				begin
					ctrl.rom_word <= `SOF_PRE_W;
					ctrl.rom_k <= 2'b00;
				end
				daq_tx_pkg::OS_DATA:
				begin
					ctrl.rom_word <= '0; // Replaced by the mux
					ctrl.rom_k <= 2'b00;
				end
				daq_tx_pkg::OS_EOP:
				begin
					ctrl.rom_word <= `EOP_W;
					ctrl.rom_k <= 2'b11;
				end
				daq_tx_pkg::OS_CEXT:
				begin
					ctrl.rom_word <= `CEXT_W;
					ctrl.rom_k <= 2'b11;
				end
				default:
				begin
					ctrl.rom_word <= `IDLE2_W;
					ctrl.rom_k <= 2'b01; // Comma low
				end
			endcase
		end
	end

endmodule

// File: rtl/crc32_word_gen.sv
`timescale 1ns/1ps

`include "daq_tx_config.svh"

module crc32_word_gen
(
	input logic usr_clk_wordwise,
	input logic arst,
	input logic [`DAQ_WORD_W-1:0] txd_i,
	frame_ctrl_if.crc ctrl,
	output logic [`DAQ_WORD_W-1:0] crc_word_o
);

	logic [31:0] crc_reg;
	logic [31:0] crc_nxt;
	logic crc_half; // Set once the high word has gone out

	// Fold one word, low octet first, bit 0 first
	always_comb
	begin
		crc_nxt = crc_reg;
		for (int i = 0; i < `DAQ_WORD_W; i++)
		begin
			if (crc_nxt[0] ^ txd_i[i])
				crc_nxt = (crc_nxt >> 1) ^ `CRC_POLY;
			else
				crc_nxt = crc_nxt >> 1;
		end
	end

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			crc_reg <= '1;
			crc_half <= 1'b0;
		end
		else
		begin
			if (ctrl.clr_crc)
				crc_reg <= '1; // Seed
			else if (ctrl.crc_calc)
				crc_reg <= crc_nxt;

			// Toggle on each CRC slot, back to the high half after two
			if (ctrl.clr_crc)
				crc_half <= 1'b0;
			else if (ctrl.crc_vld)
				crc_half <= ~crc_half;
		end
	end

	////////////////////////////////////////
	// Inverted result, high half first
	////////////////////////////////////////

	assign crc_word_o = crc_half ? ~crc_reg[15:0] : ~crc_reg[31:16];

endmodule

// File: rtl/tx_word_mux.sv
`timescale 1ns/1ps

`include "daq_tx_config.svh"

module tx_word_mux
(
	input logic usr_clk_wordwise,
	input logic arst,
	input logic [`DAQ_WORD_W-1:0] txd_i,
	input logic [`DAQ_WORD_W-1:0] crc_word_i,
	frame_ctrl_if.mux ctrl,
	output logic [`DAQ_WORD_W-1:0] mgt_tx_data_o,
	output logic [`DAQ_K_W-1:0] mgt_tx_k_o
);

	logic [`DAQ_WORD_W-1:0] data_d; // Payload, aligned with the ROM
	logic [`DAQ_WORD_W-1:0] crc_d;
	logic calc_d;
	logic vld_d;

	// Payload alignment stage
	always_ff @(posedge usr_clk_wordwise)
	begin
		data_d <= txd_i;
		crc_d <= crc_word_i;
	end

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			calc_d <= 1'b0;
			vld_d <= 1'b0;
		end
		else
		begin
			calc_d <= ctrl.crc_calc;
			vld_d <= ctrl.crc_vld;
		end
	end

	////////////////////////////////////////
	// Output register to the serializer
	////////////////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			mgt_tx_data_o <= `IDLE2_W;
			mgt_tx_k_o <= 2'b01;
		end
		else if (vld_d)
		begin
			mgt_tx_data_o <= crc_d; // CRC is plain data
			mgt_tx_k_o <= 2'b00;
		end
		else if (calc_d)
		begin
			mgt_tx_data_o <= data_d;
			mgt_tx_k_o <= 2'b00;
		end
		else
		begin
			mgt_tx_data_o <= ctrl.rom_word;
			mgt_tx_k_o <= ctrl.rom_k;
		end
	end

endmodule

// File: rtl/daq_optical_tx.sv
`timescale 1ns/1ps

`include "daq_tx_config.svh"

module daq_optical_tx
(
	input logic usr_clk_wordwise,
	input logic arst,
	input logic [`DAQ_WORD_W-1:0] txd_i,     // Payload word
	input logic txd_vld_i,                   // Request, held for the whole payload
	output logic tx_ack_o,                   // Payload window open
	output logic [`DAQ_WORD_W-1:0] mgt_tx_data_o,
	output logic [`DAQ_K_W-1:0] mgt_tx_k_o
);

	logic [`DAQ_WORD_W-1:0] crc_word; // Current CRC half

	frame_ctrl_if ctrl ();

	frame_sequencer u_seq
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst (arst),
		.txd_vld_i (txd_vld_i),
		.tx_ack_o (tx_ack_o),
		.ctrl (ctrl.seq)
	);

	crc32_word_gen u_crc
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst (arst),
		.txd_i (txd_i),
		.ctrl (ctrl.crc),
		.crc_word_o (crc_word)
	);

	tx_word_mux u_mux
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst (arst),
		.txd_i (txd_i),
		.crc_word_i (crc_word),
		.ctrl (ctrl.mux),
		.mgt_tx_data_o (mgt_tx_data_o),
		.mgt_tx_k_o (mgt_tx_k_o)
	);

endmodule

// File: testbench/daq_tx_props.sv
`timescale 1ns/1ps

`include "daq_tx_config.svh"

module daq_tx_props
(
	input logic usr_clk_wordwise,
	input logic arst,
	input logic txd_vld_i,
	input logic tx_ack_o,
	input logic [`DAQ_K_W-1:0] mgt_tx_k_o
);

	int fail_cnt = 0; // Failed assertions, read by the testbench summary

	// Acknowledge stays low while the core is held in reset
	ack_in_reset: assert property (@(posedge usr_clk_wordwise) arst |-> !tx_ack_o)
		else
		begin
			fail_cnt++;
			$error("tx_ack_o high during reset");
		end

	// Window closes one clock after the request drops
	ack_without_req: assert property (@(posedge usr_clk_wordwise) disable iff (arst)
		!txd_vld_i |=> !tx_ack_o)
		else
		begin
			fail_cnt++;
			$error("tx_ack_o high without a request");
		end

	// No ordered set carries a K character in the high octet alone
	k_flag_legal: assert property (@(posedge usr_clk_wordwise) disable iff (arst)
		mgt_tx_k_o != 2'b10)
		else
		begin
			fail_cnt++;
			$error("K flag 10 on the output");
		end

	// EOP goes to CEXT, CEXT goes to idle
	k_flag_after_eop: assert property (@(posedge usr_clk_wordwise) disable iff (arst)
		mgt_tx_k_o == 2'b11 |=> (mgt_tx_k_o == 2'b11 || mgt_tx_k_o == 2'b01))
		else
		begin
			fail_cnt++;
			$error("K flag 11 not followed by 11 or 01");
		end

endmodule

bind daq_optical_tx daq_tx_props i_props
(
	.usr_clk_wordwise (usr_clk_wordwise),
	.arst (arst),
	.txd_vld_i (txd_vld_i),
	.tx_ack_o (tx_ack_o),
	.mgt_tx_k_o (mgt_tx_k_o)
);

// File: testbench/tb_daq_optical_tx.sv
`timescale 1ns/1ps

`include "daq_tx_config.svh"

module tb_daq_optical_tx;

	localparam int NUM_PKTS = 20;
	localparam int TIMEOUT = 200; // Cycles allowed per wait

	// Monitor states
	localparam int M_IDLE = 0;
	localparam int M_PRE = 1;
	localparam int M_SOF = 2;
	localparam int M_BODY = 3;
	localparam int M_CEXT = 4;

	logic usr_clk_wordwise = 1'b0;
	logic arst;
	logic [`DAQ_WORD_W-1:0] txd_i;
	logic txd_vld_i;
	logic tx_ack_o;
	logic [`DAQ_WORD_W-1:0] mgt_tx_data_o;
	logic [`DAQ_K_W-1:0] mgt_tx_k_o;

	integer seed = 32'hbb991403;
	int err_cnt = 0;
	int chk_cnt = 0;
	int pkts_done = 0;                    // Packets closed by the monitor
	int mstate = M_IDLE;
	int pre_seen = 0;
	logic [`DAQ_WORD_W-1:0] exp_words[$]; // Transferred payload in order
	int exp_lens[$];                      // Transfers per packet
	logic [`DAQ_WORD_W-1:0] body[$];      // Payload and CRC words off the wire

	always #5 usr_clk_wordwise = ~usr_clk_wordwise;

	daq_optical_tx i_dut
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst (arst),
		.txd_i (txd_i),
		.txd_vld_i (txd_vld_i),
		.tx_ack_o (tx_ack_o),
		.mgt_tx_data_o (mgt_tx_data_o),
		.mgt_tx_k_o (mgt_tx_k_o)
	);

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		chk_cnt++;
		if (actual !== expected)
		begin
			err_cnt++;
			$display("[FAIL] %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic finish_run();
		int total;
		total = err_cnt + i_dut.i_props.fail_cnt;
		$display("Checks %0d, errors %0d, assertion failures %0d, packets %0d",
			chk_cnt, err_cnt, i_dut.i_props.fail_cnt, pkts_done);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		err_cnt++;
		$display("Timeout, no %s within %0d cycles", what, TIMEOUT);
		finish_run();
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Reflected CRC-32 over one octet with bit 0 first
	function automatic logic [31:0] crc_fold_octet(input logic [31:0] crc,
		input logic [7:0] octet);
		logic [31:0] c;
		c = crc ^ {24'h0, octet};
		for (int b = 0; b < 8; b++)
			c = c[0] ? ((c >> 1) ^ `CRC_POLY) : (c >> 1);
		return c;
	endfunction

	// Compare the collected body against the expected payload and its CRC
	task automatic check_packet();
		int len;
		logic [31:0] crc;
		logic [`DAQ_WORD_W-1:0] w;
		if (exp_lens.size() == 0)
		begin
			err_cnt++;
			$display("A packet came out with no request behind it");
			return;
		end
		len = exp_lens.pop_front();
		check_value(32'(body.size()), 32'(len + 2),
			$sformatf("packet %0d word count", pkts_done));
		crc = '1; // Seed
		for (int i = 0; i < len; i++)
		begin
			w = exp_words.pop_front();
			crc = crc_fold_octet(crc, w[7:0]);  // Low octet first
			crc = crc_fold_octet(crc, w[15:8]);
			if (i < body.size())
				check_value(32'(body[i]), 32'(w),
					$sformatf("packet %0d payload %0d", pkts_done, i));
		end
		crc = ~crc;
		if (body.size() == len + 2)
		begin
			check_value(32'(body[len]), 32'(crc[31:16]),
				$sformatf("packet %0d CRC high", pkts_done));
			check_value(32'(body[len+1]), 32'(crc[15:0]),
				$sformatf("packet %0d CRC low", pkts_done));
		end
	endtask

	////////////////////////////////////////
	// Output monitor sampling on the falling edge
	////////////////////////////////////////

	always @(negedge usr_clk_wordwise)
	begin
		if (!arst)
		begin
			case (mstate)
				M_IDLE:
					if (mgt_tx_data_o == `SOP_PRE_W)
					begin
						check_value(32'(mgt_tx_k_o), 32'h1, "SOP K flag");
						pre_seen = 0;
						mstate = M_PRE;
					end
					else
					begin
						check_value(32'(mgt_tx_data_o), 32'(`IDLE2_W), "idle word");
						check_value(32'(mgt_tx_k_o), 32'h1, "idle K flag");
					end
				M_PRE:
				begin
					check_value(32'(mgt_tx_data_o), 32'(`PREAMBLE_W), "preamble word");
					check_value(32'(mgt_tx_k_o), 32'h0, "preamble K flag");
					pre_seen++;
					if (pre_seen == `PREAMBLE_WORDS)
						mstate = M_SOF;
				end
				M_SOF:
				begin
					check_value(32'(mgt_tx_data_o), 32'(`SOF_PRE_W), "SOF word");
					check_value(32'(mgt_tx_k_o), 32'h0, "SOF K flag");
					body.delete();
					mstate = M_BODY;
				end
				M_BODY:
					if (mgt_tx_k_o == 2'b11) // First K word closes the body
					begin
						check_value(32'(mgt_tx_data_o), 32'(`EOP_W), "EOP word");
						check_packet();
						mstate = M_CEXT;
					end
					else
					begin
						check_value(32'(mgt_tx_k_o), 32'h0, "body K flag");
						body.push_back(mgt_tx_data_o);
					end
				M_CEXT:
				begin
					check_value(32'(mgt_tx_data_o), 32'(`CEXT_W), "CEXT word");
					check_value(32'(mgt_tx_k_o), 32'h3, "CEXT K flag");
					pkts_done++;
					mstate = M_IDLE;
				end
				default: mstate = M_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Driver
	////////////////////////////////////////

	task automatic send_packet(input int len);
		logic [31:0] rnd;
		logic [`DAQ_WORD_W-1:0] words[$];
		int cycles;
		int xfers;
		for (int i = 0; i < len; i++)
		begin
			rnd = $random(seed);
			words.push_back(rnd[15:0]);
		end
		txd_i = words[0];
		txd_vld_i = 1'b1;
		@(posedge usr_clk_wordwise); // Request sampled here
		#1;
		cycles = 0;
		while (!tx_ack_o)
		begin
			if (cycles == TIMEOUT)
				report_timeout("rise of tx_ack_o");
			@(posedge usr_clk_wordwise);
			#1;
			cycles++;
		end
		check_value(32'(cycles), 32'(1 + `PREAMBLE_WORDS + 1), "tx_ack_o rise latency");
		xfers = 0;
		for (int i = 0; i < len; i++)
		begin
			txd_i = words[i];
			if (tx_ack_o) // Next edge takes this word
			begin
				xfers++;
				exp_words.push_back(words[i]);
			end
			@(posedge usr_clk_wordwise);
			#1;
		end
		exp_lens.push_back(xfers);
		check_value(32'(xfers), 32'(len), "transfers in the payload window");
		txd_vld_i = 1'b0;
		rnd = $random(seed);
		txd_i = rnd[15:0]; // Junk on the bus that must not reach the wire
		cycles = 0;
		while (tx_ack_o)
		begin
			if (cycles == TIMEOUT)
				report_timeout("fall of tx_ack_o");
			@(posedge usr_clk_wordwise);
			#1;
			cycles++;
		end
		check_value(32'(cycles), 32'd1, "tx_ack_o fall latency");
	endtask

	initial
	begin
		logic [31:0] rnd;
		int len;
		int gap;
		int cycles;
		arst = 1'b1;
		txd_i = '0;
		txd_vld_i = 1'b0;
		repeat (2) @(posedge usr_clk_wordwise);
		#1;
		arst = 1'b0;
		repeat (8) @(posedge usr_clk_wordwise); // Idle words only
		#1;
		for (int p = 0; p < NUM_PKTS; p++)
		begin
			rnd = $random(seed);
			len = 1 + int'(rnd[3:0]); // 1 to 16 words
			send_packet(len);
			cycles = 0;
			while (pkts_done <= p) // Wait for CEXT so the sequencer is back in idle
			begin
				if (cycles == TIMEOUT)
					report_timeout("end of packet on the output");
				@(posedge usr_clk_wordwise);
				#1;
				cycles++;
			end
			rnd = $random(seed);
			gap = int'(rnd[2:0]);
			repeat (gap)
			begin
				@(posedge usr_clk_wordwise);
				#1;
			end
		end
		repeat (4) @(posedge usr_clk_wordwise);
		#1;
		finish_run();
	end

endmodule

// File: vlog.f
+incdir+include
rtl/daq_tx_pkg.sv
rtl/frame_ctrl_if.sv
rtl/frame_sequencer.sv
rtl/crc32_word_gen.sv
rtl/tx_word_mux.sv
rtl/daq_optical_tx.sv
testbench/daq_tx_props.sv
testbench/tb_daq_optical_tx.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_daq_optical_tx

out=$(./obj_dir/Vtb_daq_optical_tx)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'
then
	exit 0
fi
exit 1
